/* bench/mmu_isr_assert.sv */
module mmu_isr_assert
    import mmu_pkg::*;
(
    input logic                 aclk,
    input logic                 aresetn,
    input logic [N_REGIONS-1:0] req_ready,
    input logic [N_REGIONS-1:0] region_en,
    input logic [N_REGIONS-1:0] rsp_done,
    input logic                 host_valid,
    input logic                 card_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // One region served per cycle
    a_one_grant: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(req_ready))
        else $error("more than one req_ready high at once");

    // Both engines see the same valid
    a_valid_pair: assert property (@(posedge aclk) disable iff (!aresetn)
        host_valid == card_valid)
        else $error("host_valid and card_valid differ");

    // Masked regions stay out
    a_no_disabled: assert property (@(posedge aclk) disable iff (!aresetn)
        (req_ready & ~region_en) == '0)
        else $error("req_ready given to a disabled region");

    // Quiet outputs while reset is held
    a_reset_quiet: assert property (@(posedge aclk)
        !aresetn |-> (req_ready == '0 && !host_valid && !card_valid && rsp_done == '0))
        else $error("control output high during reset");

endmodule

/* bench/mmu_isr_tb.sv */
module mmu_isr_tb
    import mmu_pkg::*;
    import dma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    // Handshakes per traffic test
    localparam int N_TXN      = 80;
    // Worst cycles per transaction, done delay plus engine stalls
    localparam int MAX_WAIT   = 40;
    localparam int TOTAL_TXN  = 4 * N_TXN;

    // Requests and ready engines already present while reset is held
    logic                         aclk       = 1'b0;
    logic                         aresetn    = 1'b0;
    logic         [N_REGIONS-1:0] req_valid  = '1;
    logic         [N_REGIONS-1:0] req_ready;
    dma_isr_req_t [N_REGIONS-1:0] req        = '0;
    logic         [N_REGIONS-1:0] rsp_done;
    logic                         host_valid;
    dma_req_t                     host_req;
    logic                         host_ready = 1'b1;
    logic                         host_done  = 1'b0;
    logic                         card_valid;
    dma_req_t                     card_req;
    logic                         card_ready = 1'b1;
    logic                         card_done  = 1'b0;
    logic                         cfg_we     = 1'b0;
    cfg_addr_t                    cfg_addr   = '0;
    cnt_t                         cfg_wdata  = '0;
    cnt_t                         cfg_rdata;

    // Stimulus knobs
    int   pend_pct  = 0;
    int   last_pct  = 50;
    int   ready_pct = 75;
    bit   hold_done = 1'b0;

    // Expected state, kept by the checker
    region_t              exp_q[$];
    int                   ptr       = 0;
    int                   hs_count  = 0;
    logic [N_REGIONS-1:0] en_shadow = '1;
    cnt_t                 cnt_seen  [N_REGIONS] = '{default: '0};
    int                   grant_cnt [N_REGIONS] = '{default: 0};
    int                   served    [N_REGIONS] = '{default: 0};
    int                   done_wait = 0;

    int errors       = 0;
    int checks       = 0;
    int tests        = 0;
    int failed_tests = 0;

    mmu_isr_top #(.RDWR(0)) dut (.*);

    bind mmu_isr_top mmu_isr_assert inst_assert (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_ready  (req_ready),
        .region_en  (region_en),
        .rsp_done   (rsp_done),
        .host_valid (host_valid),
        .card_valid (card_valid)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // ------------------------------------------------------------------------
    // Reference model and compare
    // ------------------------------------------------------------------------

    // First pending and enabled region from p onward, -1 if none
    function automatic int ref_winner(input logic [N_REGIONS-1:0] pend,
                                      input logic [N_REGIONS-1:0] en, input int p);
        int idx;
        for (int i = 0; i < N_REGIONS; i++) begin
            idx = (p + i) % N_REGIONS;
            if (pend[idx] && en[idx])
                return idx;
        end
        return -1;
    endfunction

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Regions and engines, driven on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge aclk) begin
        if (aresetn) begin
            host_ready = ($urandom % 100) < ready_pct;
            card_ready = ($urandom % 100) < ready_pct;
            // Ignored with RDWR 0
            host_done  = 1'($urandom % 2);
            card_done  = 1'b0;
            // Done pulses in order, 1 to 8 cycles apart
            if (exp_q.size() == 0) begin
                done_wait = 1 + int'($urandom % 8);
            end else if (!hold_done) begin
                done_wait--;
                if (done_wait <= 0) begin
                    card_done = 1'b1;
                    done_wait = 1 + int'($urandom % 8);
                end
            end
            for (int r = 0; r < N_REGIONS; r++) begin
                // Drop the descriptor once the checker saw its handshake
                if (grant_cnt[r] != served[r]) begin
                    served[r]    = grant_cnt[r];
                    req_valid[r] = 1'b0;
                end
                if (!req_valid[r] && ($urandom % 100) < pend_pct) begin
                    req[r].paddr_host = paddr_t'({$urandom, $urandom});
                    req[r].paddr_card = paddr_t'({$urandom, $urandom});
                    req[r].len        = len_t'($urandom);
                    req[r].last       = ($urandom % 100) < last_pct;
                    req_valid[r]      = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checker
    // ------------------------------------------------------------------------
    always @(posedge aclk) begin
        int                   win;
        bit                   full;
        logic [N_REGIONS-1:0] exp_rdy;
        if (aresetn) begin
            full    = exp_q.size() >= N_OUTSTANDING;
            win     = ref_winner(req_valid, en_shadow, ptr);
            exp_rdy = '0;
            if (win >= 0 && host_ready && card_ready && !full)
                exp_rdy[win] = 1'b1;
            compare("req_ready", 64'(req_ready), 64'(exp_rdy));
            compare("card_valid", 64'(card_valid), 64'(host_valid));
            if (host_valid && !(host_ready && card_ready)) begin
                errors++;
                $display("%0d ns: engine valid high while an engine was not ready", $time);
            end
            // Oldest waiting owner gets the done
            if (card_done) begin
                compare("rsp_done", 64'(rsp_done), 64'(1) << exp_q[0]);
                void'(exp_q.pop_front());
            end else begin
                compare("rsp_done", 64'(rsp_done), 64'(0));
            end
            for (int r = 0; r < N_REGIONS; r++) begin
                if (rsp_done[r])
                    cnt_seen[r]++;
            end
            if (exp_rdy != '0) begin
                compare("host_valid", 64'(host_valid), 64'(1));
                compare("host_req.paddr", 64'(host_req.paddr), 64'(req[win].paddr_host));
                compare("card_req.paddr", 64'(card_req.paddr), 64'(req[win].paddr_card));
                compare("host_req.len", 64'(host_req.len), 64'(req[win].len));
                compare("card_req.len", 64'(card_req.len), 64'(req[win].len));
                compare("host_req.last", 64'(host_req.last), 64'(req[win].last));
                compare("card_req.last", 64'(card_req.last), 64'(req[win].last));
                compare("host_req.rsrvd", 64'(host_req.rsrvd), 64'(0));
                compare("card_req.rsrvd", 64'(card_req.rsrvd), 64'(0));
                if (req[win].last)
                    exp_q.push_back(region_t'(win));
                grant_cnt[win]++;
                ptr = (ptr + 1) % N_REGIONS;
                hs_count++;
            end else begin
                compare("host_valid", 64'(host_valid), 64'(0));
            end
            // Register writes land on this edge, clear wins over a done
            if (cfg_we && cfg_addr == CFG_ADDR_EN)
                en_shadow = cfg_wdata[N_REGIONS-1:0];
            else if (cfg_we && cfg_addr >= CFG_ADDR_CNT)
                cnt_seen[int'(cfg_addr) - int'(CFG_ADDR_CNT)] = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Sequence helpers
    // ------------------------------------------------------------------------
    task automatic wait_handshakes(input int n);
        int target;
        target = hs_count + n;
        do begin
            @(posedge aclk);
            #1;
        end while (hs_count < target);
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input cnt_t data);
        @(negedge aclk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge aclk);
        cfg_we    = 1'b0;
    endtask

    task automatic read_cfg(input cfg_addr_t addr, output cnt_t data);
        @(negedge aclk);
        cfg_addr = addr;
        @(posedge aclk);
        data = cfg_rdata;
    endtask

    task automatic report_test(input string name, input int err_mark);
        tests++;
        if (errors != err_mark)
            failed_tests++;
        $display("Test %-14s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    endtask

    // Limit from the transaction count
    initial begin
        #(TOTAL_TXN * MAX_WAIT * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d ns", TOTAL_TXN * MAX_WAIT * CLK_PERIOD);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int   err_mark;
        cnt_t rd;
        void'($urandom(41));
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // All regions pending, random engine stalls
        err_mark = errors;
        @(posedge aclk);
        pend_pct = 100;
        wait_handshakes(N_TXN);
        report_test("all_pending", err_mark);

        // Random pending masks
        err_mark = errors;
        pend_pct = 40;
        wait_handshakes(N_TXN);
        report_test("random_mask", err_mark);

        // Dones held back until the queue fills
        err_mark  = errors;
        pend_pct  = 100;
        last_pct  = 100;
        ready_pct = 100;
        hold_done = 1'b1;
        do begin
            @(posedge aclk);
            #1;
        end while (exp_q.size() < N_OUTSTANDING);
        // All regions pending and both engines ready, only the full queue blocks
        repeat (6) begin
            @(posedge aclk);
            #1;
            compare("req_ready while full", 64'(req_ready), 64'(0));
        end
        hold_done = 1'b0;
        wait_handshakes(1);
        last_pct  = 50;
        ready_pct = 75;
        report_test("queue_full", err_mark);

        // Regions 1 and 3 masked off
        err_mark = errors;
        write_cfg(CFG_ADDR_EN, cnt_t'(4'b0101));
        read_cfg(CFG_ADDR_EN, rd);
        compare("cfg_rdata enable", 64'(rd), 64'(4'b0101));
        pend_pct = 60;
        wait_handshakes(N_TXN);
        write_cfg(CFG_ADDR_EN, cnt_t'(4'b1111));
        report_test("region_mask", err_mark);

        // Drain, then read and clear the counters
        err_mark = errors;
        @(posedge aclk);
        #1;
        pend_pct = 0;
        do begin
            @(posedge aclk);
            #1;
        end while (req_valid != '0 || exp_q.size() != 0);
        for (int r = 0; r < N_REGIONS; r++) begin
            read_cfg(cfg_addr_t'(int'(CFG_ADDR_CNT) + r), rd);
            compare($sformatf("cnt[%0d]", r), 64'(rd), 64'(cnt_seen[r]));
        end
        write_cfg(cfg_addr_t'(int'(CFG_ADDR_CNT) + 2), '0);
        read_cfg(cfg_addr_t'(int'(CFG_ADDR_CNT) + 2), rd);
        compare("cnt[2] after clear", 64'(rd), 64'(0));
        read_cfg(cfg_addr_t'(int'(CFG_ADDR_CNT) + 1), rd);
        compare("cnt[1] kept", 64'(rd), 64'(cnt_seen[1]));
        report_test("counters", err_mark);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the ISR arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mmu_isr_tb -f verilog.f -o mmu_isr_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mmu_isr_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Verdict comes from the log only
if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* verilog.f */
verilog/mmu_pkg.sv
verilog/dma_pkg.sv
verilog/seq_fifo.sv
verilog/mmu_arbiter_isr.sv
verilog/isr_region_ctrl.sv
verilog/mmu_isr_top.sv
bench/mmu_isr_assert.sv
bench/mmu_isr_tb.sv

/* verilog/dma_pkg.sv */
package dma_pkg;

    import mmu_pkg::*;

    // ------------------------------------------------------------------------
    // Descriptors
    // ------------------------------------------------------------------------

    // Pad bits of an engine request, always zero here
    localparam int RSRVD_BITS = 3;

    // One descriptor as offered by a region
    // Host and card addresses of the same transfer
    typedef struct packed {
        paddr_t paddr_host;
        paddr_t paddr_card;
        len_t   len;
        // Ends a message, a done is expected for it
        logic   last;
    } dma_isr_req_t;

    // Request to a single engine
    typedef struct packed {
        paddr_t                paddr;
        len_t                  len;
        logic                  last;
        logic [RSRVD_BITS-1:0] rsrvd;
    } dma_req_t;

    // ------------------------------------------------------------------------
    // Register port
    // ------------------------------------------------------------------------
    typedef logic [2:0] cfg_addr_t;

    // Enable mask, one bit per region
    localparam cfg_addr_t CFG_ADDR_EN  = 3'd0;

    // Counters of regions 0 to 3 from here on
    localparam cfg_addr_t CFG_ADDR_CNT = 3'd4;

endpackage

/* verilog/isr_region_ctrl.sv */
module isr_region_ctrl
    import mmu_pkg::*;
    import dma_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,

    // Register port
    input  logic                 cfg_we,
    input  cfg_addr_t            cfg_addr,
    input  cnt_t                 cfg_wdata,
    output cnt_t                 cfg_rdata,

    // To and from the arbiter
    output logic [N_REGIONS-1:0] region_en,
    input  logic [N_REGIONS-1:0] rsp_done
);

    cnt_t    cnt_q [N_REGIONS];
    logic    cnt_sel;
    region_t cnt_idx;

    // Counter window decode
    assign cnt_sel = (cfg_addr >= CFG_ADDR_CNT);
    assign cnt_idx = region_t'(cfg_addr - CFG_ADDR_CNT);

    // ------------------------------------------------------------------------
    // Enable mask
    // ------------------------------------------------------------------------

    // All regions enabled out of reset
    always_ff @(posedge aclk) begin
        if (!aresetn)
            region_en <= '1;
        else if (cfg_we && cfg_addr == CFG_ADDR_EN)
            region_en <= cfg_wdata[N_REGIONS-1:0];
    end

    // ------------------------------------------------------------------------
    // Completion counters
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < N_REGIONS; i++) begin : g_cnt
        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                cnt_q[i] <= '0;
            end else if (cfg_we && cnt_sel && cnt_idx == region_t'(i)) begin
                // Write clears, wins over a done in the same cycle
                cnt_q[i] <= '0;
            end else if (rsp_done[i]) begin
                // Wraps at CNT_BITS
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // Read mux, unmapped addresses read zero
    always_comb begin
        cfg_rdata = '0;
        if (cnt_sel)
            cfg_rdata = cnt_q[cnt_idx];
        else if (cfg_addr == CFG_ADDR_EN)
            cfg_rdata[N_REGIONS-1:0] = region_en;
    end

endmodule

/* verilog/mmu_arbiter_isr.sv */
module mmu_arbiter_isr
    import mmu_pkg::*;
    import dma_pkg::*;
#(
    // 0 read, done from card engine; 1 write, done from host engine
    parameter int RDWR = 0
) (
    input  logic                          aclk,
    input  logic                          aresetn,

    // Region side
    input  logic         [N_REGIONS-1:0]  region_en,
    input  logic         [N_REGIONS-1:0]  req_valid,
    output logic         [N_REGIONS-1:0]  req_ready,
    input  dma_isr_req_t [N_REGIONS-1:0]  req,
    output logic         [N_REGIONS-1:0]  rsp_done,

    // Engine side
    output logic                          host_valid,
    output dma_req_t                      host_req,
    input  logic                          host_ready,
    output logic                          card_valid,
    output dma_req_t                      card_req,
    input  logic                          card_ready,
    input  logic                          host_done,
    input  logic                          card_done
);

    logic [N_REGIONS-1:0] eligible;
    logic                 found;
    region_t              winner;
    region_t              rr_reg;
    dma_isr_req_t         sel;

    logic                 eng_ready;
    logic                 grant;
    logic                 done_src;

    // Completion queue
    logic                 seq_push;
    logic                 seq_ready;
    region_t              seq_head;

    // ------------------------------------------------------------------------
    // Round-robin selection
    // ------------------------------------------------------------------------

    // Disabled regions drop out of arbitration
    assign eligible = req_valid & region_en;

    // First eligible region at or after the pointer, wrapping
    always_comb begin
        int idx;
        idx    = 0;
        found  = 1'b0;
        winner = rr_reg;
        for (int i = 0; i < N_REGIONS; i++) begin
            idx = int'(rr_reg) + i;
            if (idx >= N_REGIONS)
                idx = idx - N_REGIONS;
            if (!found && eligible[idx]) begin
                found  = 1'b1;
                winner = region_t'(idx);
            end
        end
    end

    // Both engines take it in the same cycle, and the queue must have room
    // Nothing granted while reset is held
    assign eng_ready = host_ready & card_ready;
    assign grant     = aresetn & found & eng_ready & seq_ready;

    assign req_ready = grant ? (N_REGIONS'(1) << winner) : '0;

    // Pointer steps by one per handshake, not past the winner
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr_reg <= '0;
        end else if (grant) begin
            if (rr_reg == region_t'(N_REGIONS - 1))
                rr_reg <= '0;
            else
                rr_reg <= rr_reg + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Duplication to both engines
    // ------------------------------------------------------------------------
    assign sel = req[winner];

    assign host_valid = grant;
    assign card_valid = grant;

    assign host_req = '{paddr: sel.paddr_host, len: sel.len, last: sel.last, rsrvd: '0};
    assign card_req = '{paddr: sel.paddr_card, len: sel.len, last: sel.last, rsrvd: '0};

    // ------------------------------------------------------------------------
    // Completion routing
    // ------------------------------------------------------------------------
    if (RDWR == 0) begin : g_done_card
        assign done_src = card_done;
    end else begin : g_done_host
        assign done_src = host_done;
    end

    // Only message ends get a done back
    assign seq_push = grant & sel.last;

    seq_fifo #(
        .DEPTH      (N_OUTSTANDING)
    ) inst_seq_done (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .push       (seq_push),
        .push_ready (seq_ready),
        .push_data  (winner),
        .pop        (done_src),
        .pop_data   (seq_head)
    );

    // Done goes to the oldest owner, queue pops on the same edge
    assign rsp_done = done_src ? (N_REGIONS'(1) << seq_head) : '0;

endmodule

/* verilog/mmu_isr_top.sv */
module mmu_isr_top
    import mmu_pkg::*;
    import dma_pkg::*;
#(
    parameter int RDWR = 0
) (
    input  logic                          aclk,
    input  logic                          aresetn,

    // Regions
    input  logic         [N_REGIONS-1:0]  req_valid,
    output logic         [N_REGIONS-1:0]  req_ready,
    input  dma_isr_req_t [N_REGIONS-1:0]  req,
    output logic         [N_REGIONS-1:0]  rsp_done,

    // Host engine
    output logic                          host_valid,
    output dma_req_t                      host_req,
    input  logic                          host_ready,
    input  logic                          host_done,

    // Card engine
    output logic                          card_valid,
    output dma_req_t                      card_req,
    input  logic                          card_ready,
    input  logic                          card_done,

    // Register port
    input  logic                          cfg_we,
    input  cfg_addr_t                     cfg_addr,
    input  cnt_t                          cfg_wdata,
    output cnt_t                          cfg_rdata
);

    logic [N_REGIONS-1:0] region_en;

    // Mask and counters
    isr_region_ctrl inst_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .region_en  (region_en),
        .rsp_done   (rsp_done)
    );

    // Selection and completion routing
    mmu_arbiter_isr #(
        .RDWR       (RDWR)
    ) inst_arb (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .region_en  (region_en),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_done   (rsp_done),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_ready (host_ready),
        .card_valid (card_valid),
        .card_req   (card_req),
        .card_ready (card_ready),
        .host_done  (host_done),
        .card_done  (card_done)
    );

endmodule

/* verilog/mmu_pkg.sv */
package mmu_pkg;

    // ------------------------------------------------------------------------
    // Sizing
    // ------------------------------------------------------------------------

    // Virtual regions sharing the ISR path
    localparam int N_REGIONS      = 4;
    localparam int N_REGIONS_BITS = 2;

    // Transfers with last set that can wait for a done
    localparam int N_OUTSTANDING  = 4;

    localparam int PADDR_BITS     = 48;
    localparam int LEN_BITS       = 28;

    // Per-region completion counter, wraps
    localparam int CNT_BITS       = 16;

    // ------------------------------------------------------------------------
    // Plain vectors
    // ------------------------------------------------------------------------
    typedef logic [N_REGIONS_BITS-1:0] region_t;
    typedef logic [PADDR_BITS-1:0]     paddr_t;
    typedef logic [LEN_BITS-1:0]       len_t;
    typedef logic [CNT_BITS-1:0]       cnt_t;

endpackage

/* verilog/seq_fifo.sv */
module seq_fifo
    import mmu_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic    aclk,
    input  logic    aresetn,

    input  logic    push,
    output logic    push_ready,
    input  region_t push_data,

    input  logic    pop,
    output region_t pop_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_BITS = $clog2(DEPTH + 1);

    region_t               mem [DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [OCC_BITS-1:0]   count;
    logic                  push_en;
    logic                  pop_en;

    // Circular increment, DEPTH need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign push_ready = (count != OCC_BITS'(DEPTH));
    assign push_en    = push & push_ready;
    // Pop on empty is dropped
    assign pop_en     = pop & (count != '0);

    // Head always visible
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push_en)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop_en)
                rd_ptr <= ptr_inc(rd_ptr);
            // Occupancy, unchanged on push with pop
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
